// File: hdl/cpuPkg.sv
package cpuPkg;

    localparam int DataWidth   = 8;   // Bus, register and memory word
    localparam int AddrWidth   = 8;
    localparam int InstrWidth  = 8;   // One ROM byte per instruction or operand
    localparam int BusSelWidth = 4;
    localparam int AluOpWidth  = 2;

    // Upper nibble of an instruction
    localparam logic [3:0]
        OpNoop   = 4'd0,
        OpJmp    = 4'd1,
        OpCopy   = 4'd2,   // N1 only
        OpLoad   = 4'd3,
        OpStore  = 4'd4,
        OpAssign = 4'd5,
        OpReset  = 4'd6,
        OpMove   = 4'd7,
        OpSet    = 4'd8,
        OpMul    = 4'd9,
        OpAdd    = 4'd10,  // T into AC
        OpInc    = 4'd11,
        OpEnd    = 4'd15;

    // Lower nibble, meaning depends on the opcode
    localparam logic [3:0]
        JmpN     = 4'd2,
        LoadC1   = 4'd0,
        LoadC2   = 4'd1,
        AssignC1 = 4'd0,
        AssignC2 = 4'd1,
        AssignC3 = 4'd2,
        ResetAll = 4'd0,
        ResetN2  = 4'd1,
        MoveP    = 4'd0,
        MoveT    = 4'd1,
        MoveC1   = 4'd2,
        SetC1    = 4'd0,
        SetDr    = 4'd1,
        IncC2    = 4'd0,
        IncC3    = 4'd1,
        IncN2    = 4'd2;

    // Shared bus sources
    localparam logic [BusSelWidth-1:0]
        BusNone = 4'd0,    // Bus reads as zero
        BusMem  = 4'd1,
        BusAr   = 4'd2,
        BusDr   = 4'd3,
        BusP    = 4'd4,
        BusT    = 4'd5,
        BusN1   = 4'd6,
        BusC1   = 4'd7,
        BusC2   = 4'd8,
        BusC3   = 4'd9,
        BusAc   = 4'd10,
        BusRom  = 4'd11;

    // Bit positions in the register write vector
    localparam int
        RegPc   = 0,
        RegIr   = 1,
        RegAr   = 2,
        RegDr   = 3,
        RegP    = 4,
        RegT    = 5,
        RegN1   = 6,
        RegC1   = 7,
        RegC2   = 8,
        RegC3   = 9,
        RegAc   = 10,
        NumRegs = 11;

    localparam int
        IncPcBit = 0,
        IncN2Bit = 1,
        IncC2Bit = 2,
        IncC3Bit = 3,
        NumIncs  = 4;

    localparam int
        ClrT    = 0,
        ClrN2   = 1,
        ClrAc   = 2,
        NumClrs = 3;

    localparam logic [AluOpWidth-1:0]
        AluNone = 2'd0,
        AluSet  = 2'd1,
        AluAdd  = 2'd2,
        AluMul  = 2'd3;

    // The same ROM byte is either an instruction or an immediate operand
    typedef union packed {
        struct packed {
            logic [3:0] op;
            logic [3:0] sub;
        } f;
        logic [InstrWidth-1:0] imm;
    } instrWord_u;

endpackage

// File: hdl/ctrlBus_if.sv
`timescale 1ns/1ps

interface ctrlBus_if
    import cpuPkg::*;
();

    logic [NumRegs-1:0]     regWrite;  // One load enable per register
    logic [BusSelWidth-1:0] busSrc;    // Who owns the shared bus
    logic [NumIncs-1:0]     incEn;
    logic [NumClrs-1:0]     clrEn;
    logic [AluOpWidth-1:0]  aluOp;

    // Control word source
    modport ctrl (
        output regWrite, busSrc, incEn, clrEn, aluOp
    );

    // Datapath peers only listen
    modport dp (
        input regWrite, busSrc, incEn, clrEn, aluOp
    );

endinterface

// File: hdl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
    import cpuPkg::*;
(
    input  logic       Clk,
    input  logic       rstN,
    ctrlBus_if.ctrl    cb,
    input  instrWord_u instr,
    input  logic       zero,
    output logic       iromRead,
    output logic       memRead,
    output logic       memWrite,
    output logic       halted
);

    localparam logic [4:0]
        SIdle    = 5'd0,
        SFetch1  = 5'd1,
        SFetch2  = 5'd2,
        SDecode  = 5'd3,
        SExec    = 5'd4,   // All single-cycle instructions
        SJmpTest = 5'd5,
        SJmpRead = 5'd6,
        SJmpAr   = 5'd7,
        SJmpPc   = 5'd8,
        SJmpSkip = 5'd9,
        SAsgRead = 5'd10,
        SAsgAr   = 5'd11,
        SAsgDst  = 5'd12,
        SLdAddr  = 5'd13,
        SLdRead  = 5'd14,
        SLdData  = 5'd15,
        SStDr    = 5'd16,
        SStAddr  = 5'd17,
        SStWrite = 5'd18,
        SCpRead  = 5'd19,
        SCpAr    = 5'd20,
        SCpMemRd = 5'd21,
        SCpDr    = 5'd22,
        SCpN1    = 5'd23,
        SHalt    = 5'd24;

    logic [4:0] state;
    logic [4:0] nextState;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state <= SIdle;
        end else begin
            state <= nextState;
        end
    end

    assign halted = (state == SHalt);

    always_comb begin
        nextState   = SFetch1;  // Most sequences close back into fetch
        iromRead    = 1'b0;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        cb.regWrite = '0;
        cb.busSrc   = BusNone;
        cb.incEn    = '0;
        cb.clrEn    = '0;
        cb.aluOp    = AluNone;

        case (state)
            SFetch1: begin
                iromRead  = 1'b1;
                nextState = SFetch2;
            end
            SFetch2: begin                      // IR <= ROM[PC], PC++
                cb.busSrc          = BusRom;
                cb.regWrite[RegIr] = 1'b1;
                cb.incEn[IncPcBit] = 1'b1;
                nextState          = SDecode;
            end
            SDecode: begin
                // Bad sub-opcodes fall through to fetch
                case (instr.f.op)
                    OpJmp:    if (instr.f.sub == JmpN) nextState = SJmpTest;
                    OpCopy:   nextState = SCpRead;
                    OpLoad:   if (instr.f.sub inside {LoadC1, LoadC2}) nextState = SLdAddr;
                    OpStore:  nextState = SStDr;
                    OpAssign: begin
                        if (instr.f.sub inside {AssignC1, AssignC2, AssignC3})
                            nextState = SAsgRead;
                    end
                    OpReset, OpMove, OpSet, OpMul, OpAdd, OpInc: nextState = SExec;
                    OpEnd:    nextState = SHalt;
                    default:  nextState = SFetch1;
                endcase
            end
            SExec: begin
                case (instr.f.op)
                    OpMove: begin
                        cb.busSrc           = BusAc;
                        cb.regWrite[RegP]   = (instr.f.sub == MoveP);
                        cb.regWrite[RegT]   = (instr.f.sub == MoveT);
                        cb.regWrite[RegC1]  = (instr.f.sub == MoveC1);
                    end
                    OpSet: begin
                        cb.aluOp            = AluSet;
                        cb.busSrc           = (instr.f.sub == SetDr) ? BusDr : BusC1;
                        cb.regWrite[RegAc]  = instr.f.sub inside {SetC1, SetDr};
                    end
                    OpAdd: begin                // AC <= AC + T
                        cb.aluOp            = AluAdd;
                        cb.busSrc           = BusT;
                        cb.regWrite[RegAc]  = 1'b1;
                    end
                    OpMul: begin
                        cb.aluOp            = AluMul;
                        cb.busSrc           = BusP;
                        cb.regWrite[RegAc]  = 1'b1;
                    end
                    OpInc: begin
                        cb.incEn[IncC2Bit]  = (instr.f.sub == IncC2);
                        cb.incEn[IncC3Bit]  = (instr.f.sub == IncC3);
                        cb.incEn[IncN2Bit]  = (instr.f.sub == IncN2);
                    end
                    OpReset: begin
                        cb.clrEn[ClrT]      = (instr.f.sub == ResetAll);
                        cb.clrEn[ClrAc]     = (instr.f.sub == ResetAll);
                        cb.clrEn[ClrN2]     = instr.f.sub inside {ResetAll, ResetN2};
                    end
                    default: cb.aluOp = AluNone;
                endcase
            end
            SJmpTest: nextState = zero ? SJmpSkip : SJmpRead;  // Loop until N2 reaches N1
            SJmpSkip: cb.incEn[IncPcBit] = 1'b1;               // Step over the target byte
            SJmpRead: begin
                iromRead  = 1'b1;
                nextState = SJmpAr;
            end
            SJmpAr: begin
                cb.busSrc          = BusRom;
                cb.regWrite[RegAr] = 1'b1;
                nextState          = SJmpPc;
            end
            SJmpPc: begin
                cb.busSrc          = BusAr;
                cb.regWrite[RegPc] = 1'b1;
            end
            SAsgRead: begin
                iromRead  = 1'b1;
                nextState = SAsgAr;
            end
            SAsgAr: begin                       // AR <= immediate, PC++
                cb.busSrc          = BusRom;
                cb.regWrite[RegAr] = 1'b1;
                cb.incEn[IncPcBit] = 1'b1;
                nextState          = SAsgDst;
            end
            SAsgDst: begin
                cb.busSrc          = BusAr;
                cb.regWrite[RegC1] = (instr.f.sub == AssignC1);
                cb.regWrite[RegC2] = (instr.f.sub == AssignC2);
                cb.regWrite[RegC3] = (instr.f.sub == AssignC3);
            end
            SLdAddr: begin
                cb.busSrc          = (instr.f.sub == LoadC2) ? BusC2 : BusC1;
                cb.regWrite[RegAr] = 1'b1;
                nextState          = SLdRead;
            end
            SLdRead: begin
                memRead   = 1'b1;
                nextState = SLdData;
            end
            SLdData: begin
                cb.busSrc          = BusMem;
                cb.regWrite[RegDr] = 1'b1;
            end
            SStDr: begin
                cb.busSrc          = BusT;
                cb.regWrite[RegDr] = 1'b1;
                nextState          = SStAddr;
            end
            SStAddr: begin
                cb.busSrc          = BusC3;
                cb.regWrite[RegAr] = 1'b1;
                nextState          = SStWrite;
            end
            SStWrite: memWrite = 1'b1;          // mem[AR] <= DR
            SCpRead: begin
                iromRead  = 1'b1;
                nextState = SCpAr;
            end
            SCpAr: begin
                cb.busSrc          = BusRom;
                cb.regWrite[RegAr] = 1'b1;
                cb.incEn[IncPcBit] = 1'b1;
                nextState          = SCpMemRd;
            end
            SCpMemRd: begin
                memRead   = 1'b1;
                nextState = SCpDr;
            end
            SCpDr: begin
                cb.busSrc          = BusMem;
                cb.regWrite[RegDr] = 1'b1;
                nextState          = SCpN1;
            end
            SCpN1: begin
                cb.busSrc          = BusDr;
                cb.regWrite[RegN1] = 1'b1;
            end
            SHalt: nextState = SHalt;           // Parked until reset
            default: nextState = SFetch1;       // Idle after reset
        endcase
    end

endmodule

// File: hdl/regFile.sv
`timescale 1ns/1ps

module regFile
    import cpuPkg::*;
#(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    input  logic                  Clk,
    input  logic                  rstN,
    ctrlBus_if.dp                 cb,
    input  logic [DataWidth-1:0]  busData,
    input  logic [DataWidth-1:0]  accNext,
    output logic [DataWidth-1:0]  pc,
    output logic [DataWidth-1:0]  ar,
    output logic [DataWidth-1:0]  dr,
    output logic [DataWidth-1:0]  p,
    output logic [DataWidth-1:0]  t,
    output logic [DataWidth-1:0]  n1,
    output logic [DataWidth-1:0]  n2,
    output logic [DataWidth-1:0]  c1,
    output logic [DataWidth-1:0]  c2,
    output logic [DataWidth-1:0]  c3,
    output logic [DataWidth-1:0]  ac,
    output logic [InstrWidth-1:0] instr
);

    // Indexed by write-enable bit position
    logic [DataWidth-1:0] regs [NumRegs];

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
            n2 <= '0;
        end else begin
            for (int i = 0; i < NumRegs; i++) begin
                if (cb.regWrite[i]) begin
                    regs[i] <= (i == RegAc) ? accNext : busData;  // AC only via the ALU
                end
            end

            if (cb.incEn[IncPcBit])
                regs[RegPc] <= regs[RegPc] + 1'b1;
            if (cb.incEn[IncC2Bit])
                regs[RegC2] <= regs[RegC2] + 1'b1;
            if (cb.incEn[IncC3Bit])
                regs[RegC3] <= regs[RegC3] + 1'b1;

            // Clears come last and win
            if (cb.clrEn[ClrT])
                regs[RegT] <= '0;
            if (cb.clrEn[ClrAc])
                regs[RegAc] <= '0;

            // Loop counter, never loaded from the bus
            if (cb.clrEn[ClrN2])
                n2 <= '0;
            else if (cb.incEn[IncN2Bit])
                n2 <= n2 + 1'b1;
        end
    end

    assign pc    = regs[RegPc];
    assign ar    = regs[RegAr];
    assign dr    = regs[RegDr];
    assign p     = regs[RegP];
    assign t     = regs[RegT];
    assign n1    = regs[RegN1];
    assign c1    = regs[RegC1];
    assign c2    = regs[RegC2];
    assign c3    = regs[RegC3];
    assign ac    = regs[RegAc];
    assign instr = regs[RegIr][InstrWidth-1:0];

endmodule

// File: hdl/busArbiter.sv
`timescale 1ns/1ps

module busArbiter
    import cpuPkg::*;
#(
    parameter int DataWidth = cpuPkg::DataWidth,
    parameter int AddrWidth = cpuPkg::AddrWidth
) (
    input  logic                  Clk,
    input  logic                  rstN,
    ctrlBus_if.dp                 cb,
    input  logic [DataWidth-1:0]  memRdData,
    input  logic [InstrWidth-1:0] iromData,
    input  logic [DataWidth-1:0]  pc,
    input  logic [DataWidth-1:0]  ar,
    input  logic [DataWidth-1:0]  dr,
    input  logic [DataWidth-1:0]  p,
    input  logic [DataWidth-1:0]  t,
    input  logic [DataWidth-1:0]  n1,
    input  logic [DataWidth-1:0]  c1,
    input  logic [DataWidth-1:0]  c2,
    input  logic [DataWidth-1:0]  c3,
    input  logic [DataWidth-1:0]  ac,
    output logic [AddrWidth-1:0]  memAddr,
    output logic [AddrWidth-1:0]  iromAddr,
    output logic [DataWidth-1:0]  memWrData,
    output logic [DataWidth-1:0]  busData
);

    logic [BusSelWidth-1:0] lastSrc;
    logic [InstrWidth-1:0]  romQ;
    logic [DataWidth-1:0]   memQ;
    instrWord_u             romWord;
    logic [DataWidth-1:0]   memWord;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            lastSrc <= BusNone;
        end else begin
            lastSrc <= cb.busSrc;
        end
    end

    // Read data is only good in the cycle after the strobe.
    // Capture it there and keep it while the same source holds the bus.
    always_ff @(posedge Clk) begin
        if (lastSrc != BusRom)
            romQ <= iromData;
        if (lastSrc != BusMem)
            memQ <= memRdData;
    end

    assign romWord = (lastSrc == BusRom) ? romQ : iromData;
    assign memWord = (lastSrc == BusMem) ? memQ : memRdData;

    always_comb begin
        case (cb.busSrc)
            BusMem:  busData = memWord;
            BusRom:  busData = DataWidth'(romWord.imm);  // Operand byte, not an opcode
            BusAr:   busData = ar;
            BusDr:   busData = dr;
            BusP:    busData = p;
            BusT:    busData = t;
            BusN1:   busData = n1;
            BusC1:   busData = c1;
            BusC2:   busData = c2;
            BusC3:   busData = c3;
            BusAc:   busData = ac;
            default: busData = '0;
        endcase
    end

    assign iromAddr  = AddrWidth'(pc);
    assign memAddr   = AddrWidth'(ar);
    assign memWrData = dr;

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu
    import cpuPkg::*;
#(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    ctrlBus_if.dp                cb,
    input  logic [DataWidth-1:0] busData,
    input  logic [DataWidth-1:0] ac,
    input  logic [DataWidth-1:0] p,
    input  logic [DataWidth-1:0] n1,
    input  logic [DataWidth-1:0] n2,
    output logic [DataWidth-1:0] accNext,
    output logic                 zero
);

    // Results wrap at DataWidth
    always_comb begin
        case (cb.aluOp)
            AluSet:  accNext = busData;
            AluAdd:  accNext = busData + ac;
            AluMul:  accNext = DataWidth'(p * ac);  // P is also on the bus here
            default: accNext = ac;
        endcase
    end

    // Loop exit test for JMP N
    assign zero = (n1 == n2);

endmodule

// File: hdl/cpuTop.sv
`timescale 1ns/1ps

module cpuTop
    import cpuPkg::*;
#(
    parameter int DataWidth = cpuPkg::DataWidth,
    parameter int AddrWidth = cpuPkg::AddrWidth
) (
    input  logic                  Clk,
    input  logic                  rstN,
    output logic                  iromRead,
    output logic [AddrWidth-1:0]  iromAddr,
    input  logic [InstrWidth-1:0] iromData,
    output logic                  memRead,
    output logic                  memWrite,
    output logic [AddrWidth-1:0]  memAddr,
    output logic [DataWidth-1:0]  memWrData,
    input  logic [DataWidth-1:0]  memRdData,
    output logic                  halted
);

    ctrlBus_if cb ();

    logic [DataWidth-1:0]  busData;
    logic [DataWidth-1:0]  accNext;
    logic                  zero;
    logic [InstrWidth-1:0] instr;
    logic [DataWidth-1:0]  pc, ar, dr, p, t;
    logic [DataWidth-1:0]  n1, n2, c1, c2, c3, ac;

    controlUnit u_ctrl (
        .Clk      (Clk),
        .rstN     (rstN),
        .cb       (cb.ctrl),
        .instr    (instr),
        .zero     (zero),
        .iromRead (iromRead),
        .memRead  (memRead),
        .memWrite (memWrite),
        .halted   (halted)
    );

    regFile #(
        .DataWidth (DataWidth)
    ) u_regs (
        .Clk     (Clk),
        .rstN    (rstN),
        .cb      (cb.dp),
        .busData (busData),
        .accNext (accNext),
        .pc      (pc),
        .ar      (ar),
        .dr      (dr),
        .p       (p),
        .t       (t),
        .n1      (n1),
        .n2      (n2),
        .c1      (c1),
        .c2      (c2),
        .c3      (c3),
        .ac      (ac),
        .instr   (instr)
    );

    busArbiter #(
        .DataWidth (DataWidth),
        .AddrWidth (AddrWidth)
    ) u_arb (
        .Clk       (Clk),
        .rstN      (rstN),
        .cb        (cb.dp),
        .memRdData (memRdData),
        .iromData  (iromData),
        .pc        (pc),
        .ar        (ar),
        .dr        (dr),
        .p         (p),
        .t         (t),
        .n1        (n1),
        .c1        (c1),
        .c2        (c2),
        .c3        (c3),
        .ac        (ac),
        .memAddr   (memAddr),
        .iromAddr  (iromAddr),
        .memWrData (memWrData),
        .busData   (busData)
    );

    alu #(
        .DataWidth (DataWidth)
    ) u_alu (
        .cb      (cb.dp),
        .busData (busData),
        .ac      (ac),
        .p       (p),
        .n1      (n1),
        .n2      (n2),
        .accNext (accNext),
        .zero    (zero)
    );

endmodule

// File: testbench/tbPrograms.svh
int romPtr;

// Fills the ROM with no-ops and restarts the assembler at address 0
task automatic startProgram();
    for (int i = 0; i < 2**AddrWidth; i++) begin
        rom[i] = {OpNoop, 4'(i) ^ 4'(i >> 4)};  // Sub field of a NOOP is ignored
    end
    romPtr = 0;
endtask

task automatic emitByte(input logic [7:0] value);
    rom[romPtr] = value;
    romPtr++;
endtask

task automatic haltProgram();
    startProgram();
    emitByte({OpEnd, 4'd0});
endtask

task automatic copyWordProgram(input logic [7:0] src, input logic [7:0] dst);
    startProgram();
    emitByte({OpAssign, AssignC1});
    emitByte(src);
    emitByte({OpLoad, LoadC1});
    emitByte({OpSet, SetDr});
    emitByte({OpMove, MoveT});
    emitByte({OpAssign, AssignC3});
    emitByte(dst);
    emitByte({OpStore, 4'd0});
    emitByte({OpEnd, 4'd0});
endtask

// x at base, y at base+1; x*y goes to dst and 2*x*y to dst+1
task automatic arithmeticProgram(input logic [7:0] base, input logic [7:0] dst);
    startProgram();
    emitByte({OpAssign, AssignC2});
    emitByte(base);
    emitByte({OpLoad, LoadC2});
    emitByte({OpSet, SetDr});
    emitByte({OpMove, MoveP});
    emitByte({OpInc, IncC2});     // Step to y
    emitByte({OpLoad, LoadC2});
    emitByte({OpSet, SetDr});
    emitByte({OpMul, 4'd0});
    emitByte({OpMove, MoveT});
    emitByte({OpAssign, AssignC3});
    emitByte(dst);
    emitByte({OpStore, 4'd0});
    emitByte({OpAdd, 4'd0});      // AC = T + AC
    emitByte({OpMove, MoveT});
    emitByte({OpInc, IncC3});
    emitByte({OpStore, 4'd0});
    emitByte({OpEnd, 4'd0});
endtask

task automatic countedLoopProgram(input logic [7:0] countAddr, input logic [7:0] value,
                                  input logic [7:0] base);
    int body;
    startProgram();
    emitByte({OpAssign, AssignC1});
    emitByte(value);
    emitByte({OpAssign, AssignC3});
    emitByte(base);
    emitByte({OpCopy, 4'd0});
    emitByte(countAddr);
    emitByte({OpReset, ResetN2});
    body = romPtr;
    emitByte({OpInc, IncN2});
    emitByte({OpInc, IncC3});
    emitByte({OpSet, SetC1});
    emitByte({OpMove, MoveT});
    emitByte({OpStore, 4'd0});
    emitByte({OpJmp, JmpN});
    emitByte(8'(body));             // Back to the loop body
    emitByte({OpEnd, 4'd0});
endtask

task automatic resetAllProgram(input logic [7:0] value, input logic [7:0] dst);
    startProgram();
    emitByte({OpAssign, AssignC1});
    emitByte(value);
    emitByte({OpSet, SetC1});
    emitByte({OpMove, MoveT});
    emitByte({OpReset, ResetAll});
    emitByte({OpAssign, AssignC3});
    emitByte(dst);
    emitByte({OpStore, 4'd0});
    emitByte({OpEnd, 4'd0});
endtask

// File: testbench/tb_cpuTop.sv
`timescale 1ns/1ps

module tb_cpuTop
    import cpuPkg::*;
();

    logic                  Clk;
    logic                  rstN;
    logic                  iromRead;
    logic [AddrWidth-1:0]  iromAddr;
    logic [InstrWidth-1:0] iromData;
    logic                  memRead;
    logic                  memWrite;
    logic [AddrWidth-1:0]  memAddr;
    logic [DataWidth-1:0]  memWrData;
    logic [DataWidth-1:0]  memRdData;
    logic                  halted;

    logic [InstrWidth-1:0] rom [2**AddrWidth];
    logic [DataWidth-1:0]  mem [2**AddrWidth];
    logic                  romReq;
    logic                  memReq;
    logic [AddrWidth-1:0]  romReqAddr;
    logic [AddrWidth-1:0]  memReqAddr;
    int unsigned           lcgState = 97888;

    `include "tbPrograms.svh"

    cpuTop #(
        .DataWidth (DataWidth),
        .AddrWidth (AddrWidth)
    ) u_dut (
        .Clk       (Clk),
        .rstN      (rstN),
        .iromRead  (iromRead),
        .iromAddr  (iromAddr),
        .iromData  (iromData),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .memAddr   (memAddr),
        .memWrData (memWrData),
        .memRdData (memRdData),
        .halted    (halted)
    );

    always #2 Clk = ~Clk;

    // Strobes are taken at the rising edge and read data shows up at the next falling edge
    always @(posedge Clk) begin
        romReq     <= iromRead;
        romReqAddr <= iromAddr;
        memReq     <= memRead;
        memReqAddr <= memAddr;
        if (memWrite)
            mem[memAddr] <= memWrData;
    end

    always @(negedge Clk) begin
        if (romReq)
            iromData <= rom[romReqAddr];
        if (memReq)
            memRdData <= mem[memReqAddr];
    end

    function automatic logic [7:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[23:16];
    endfunction

    function automatic logic [DataWidth-1:0] patternAt(input int addr);
        return DataWidth'(addr) ^ 8'hA5;
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected)
            abortRun($sformatf("Fail %s: expected 0x%0h, actual 0x%0h",
                               testName, expected, actual));
    endtask

    task automatic checkQuiet(input string testName);
        checkValue({testName, " iromRead"}, 0, iromRead);
        checkValue({testName, " memRead"}, 0, memRead);
        checkValue({testName, " memWrite"}, 0, memWrite);
    endtask

    task automatic fillMemory();
        for (int i = 0; i < 2**AddrWidth; i++) begin
            mem[i] <= patternAt(i);
        end
    endtask

    task automatic applyReset();
        @(negedge Clk);
        rstN = 1'b0;
        repeat (10) @(negedge Clk);
        rstN = 1'b1;
    endtask

    task automatic waitForHalt(input string testName);
        int cycles;
        cycles = 0;
        while (!halted && cycles < 2000) begin
            @(negedge Clk);
            cycles++;
        end
        if (!halted)
            abortRun($sformatf("Test %s: halted never rose within 2000 cycles", testName));
    endtask

    task automatic testResetState();
        haltProgram();
        @(negedge Clk);
        rstN = 1'b0;
        for (int i = 0; i < 10; i++) begin
            @(negedge Clk);
            checkQuiet("resetState during reset");
            checkValue("resetState halted", 0, halted);
            checkValue("resetState iromAddr", 0, iromAddr);
        end
        rstN = 1'b1;
        checkQuiet("resetState after release");
        checkValue("resetState halted after release", 0, halted);
        @(negedge Clk);
        checkValue("resetState first fetch", 1, iromRead);  // Fetch from PC 0
        checkValue("resetState fetch address", 0, iromAddr);
        waitForHalt("resetState");
    endtask

    task automatic testCopyWord();
        logic [7:0] src;
        logic [7:0] dst;
        logic [7:0] value;
        src   = 8'h10 + (nextRandom() & 8'h0F);
        dst   = 8'h80 + (nextRandom() & 8'h0F);
        value = nextRandom();
        fillMemory();
        mem[src] <= value;
        copyWordProgram(src, dst);
        applyReset();
        waitForHalt("copyWord");
        checkValue("copyWord", value, mem[dst]);
    endtask

    task automatic testArithmetic();
        logic [7:0] x;
        logic [7:0] y;
        int         product;
        x       = nextRandom() | 8'h01;   // Odd operands give an odd product
        y       = nextRandom() | 8'h01;
        product = x * y;
        fillMemory();
        mem[8'h20] <= x;
        mem[8'h21] <= y;
        arithmeticProgram(8'h20, 8'h90);
        applyReset();
        waitForHalt("arithmetic");
        checkValue("arithmetic product", product % 256, mem[8'h90]);
        checkValue("arithmetic double", (2 * product) % 256, mem[8'h91]);
    endtask

    task automatic testCountedLoop();
        int         count;
        logic [7:0] value;
        count = 2 + nextRandom() % 4;   // At least one jump back
        value = nextRandom();
        fillMemory();
        mem[8'h30] <= 8'(count);
        countedLoopProgram(8'h30, value, 8'hA0);
        applyReset();
        waitForHalt("countedLoop");
        for (int i = 1; i <= count; i++) begin
            checkValue($sformatf("countedLoop word %0d", i), value, mem[8'hA0 + i]);
        end
        checkValue("countedLoop untouched", patternAt(8'hA0 + count + 1),
                   mem[8'hA0 + count + 1]);
    endtask

    task automatic testResetAll();
        logic [7:0] value;
        value = nextRandom() | 8'h01;   // T must hold something nonzero
        fillMemory();
        resetAllProgram(value, 8'hC0);
        applyReset();
        waitForHalt("resetAll");
        checkValue("resetAll stored T", 0, mem[8'hC0]);
        repeat (20) begin
            @(negedge Clk);
            checkValue("resetAll halted", 1, halted);
            checkQuiet("resetAll parked");
        end
    endtask

    initial begin
        Clk = 1'b0;
        rstN = 1'b0;
        iromData <= '0;
        memRdData <= '0;
        testResetState();
        testCopyWord();
        testArithmetic();
        testCountedLoop();
        testResetAll();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: compile.f
+incdir+testbench
hdl/cpuPkg.sv
hdl/ctrlBus_if.sv
hdl/controlUnit.sv
hdl/regFile.sv
hdl/busArbiter.sv
hdl/alu.sv
hdl/cpuTop.sv
testbench/tb_cpuTop.sv

// File: Bender.yml
package:
  name: cpu_top

sources:
  - hdl/cpuPkg.sv
  - hdl/ctrlBus_if.sv
  - hdl/controlUnit.sv
  - hdl/regFile.sv
  - hdl/busArbiter.sv
  - hdl/alu.sv
  - hdl/cpuTop.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_cpuTop.sv
